// File: list.f
hw/fpu_seq_pkg.sv
hw/fp_regfile.sv
hw/fp_scoreboard.sv
hw/fp_instr_decoder.sv
hw/fp_dispatcher.sv
hw/fp_retire_unit.sv
hw/fpu_sequencer.sv
sim/tb_fpu_sequencer.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_fpu_sequencer
FILELIST ?= list.f
BUILD    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL) and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD)

// File: sim/tb_fpu_sequencer.sv
////////////////////////////////////////
// FP sequencer testbench
// Random requests, vector-unit stub and
// a shadow register file as reference
////////////////////////////////////////

`timescale 1ns/1ns

module tb_fpu_sequencer;

  localparam int n_mix = 300;
  localparam int n_bp  = 104;
  // About 40 cycles per request including moves
  localparam int cycle_limit = 40 * (n_mix + n_bp + 3 * 32);

  logic                  clk_i = 1'b0;
  logic                  reset_i = 1'b1;
  fpu_seq_pkg::instr_t   core_issue_instr_i = '0;
  fpu_seq_pkg::fp_data_t core_issue_rs1_i = '0;
  fpu_seq_pkg::fp_data_t core_issue_rs2_i = '0;
  fpu_seq_pkg::fp_data_t core_issue_rs3_i = '0;
  fpu_seq_pkg::x_id_t    core_issue_id_i = '0;
  logic                  core_issue_valid_i = 1'b0;
  logic                  core_result_ready_i = 1'b0;
  logic                  vec_issue_ready_i = 1'b0;
  logic                  vec_resp_accept_i = 1'b0;
  logic                  vec_resp_writeback_i = 1'b0;
  logic                  vec_resp_exc_i = 1'b0;
  fpu_seq_pkg::x_id_t    vec_result_id_i = '0;
  fpu_seq_pkg::fp_data_t vec_result_data_i = '0;
  logic                  vec_result_valid_i = 1'b0;
  logic                  core_issue_ready_o, core_resp_accept_o;
  logic                  core_resp_writeback_o, core_resp_exc_o;
  fpu_seq_pkg::x_id_t    core_result_id_o, vec_issue_id_o;
  fpu_seq_pkg::fp_data_t core_result_data_o;
  logic                  core_result_valid_o, vec_issue_valid_o, vec_result_ready_o;
  fpu_seq_pkg::instr_t   vec_issue_instr_o;
  fpu_seq_pkg::fp_data_t vec_issue_rs1_o, vec_issue_rs2_o, vec_issue_rs3_o;

  // Reference model and stub state
  fpu_seq_pkg::fp_data_t shadow [32];
  bit [31:0]             pending = '0;
  fpu_seq_pkg::x_id_t    res_queue [$];
  logic [37:0]           move_q [$];
  bit                    res_taken = 1'b0;
  int                    res_wait = 0;
  int unsigned           ready_rate = 80;
  int                    checks = 0, errors = 0, test_checks, test_errors;
  int                    cycles = 0;
  string                 cur_test = "reset";

  fpu_sequencer #(.fdiv_sqrt_en(1'b0)) u_fpu_sequencer (.*);

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic require(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("%s: %s", cur_test, msg);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Vector-unit stub
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    vec_issue_ready_i    <= $urandom_range(99) < 70;
    vec_resp_accept_i    <= 1'($urandom_range(1));
    vec_resp_writeback_i <= 1'($urandom_range(1));
    vec_resp_exc_i       <= $urandom_range(9) == 0;
    core_result_ready_i  <= $urandom_range(99) < ready_rate;
    if (!vec_result_valid_i || res_taken) begin
      if (res_queue.size() != 0 && res_wait == 0) begin
        vec_result_valid_i <= 1'b1;
        vec_result_id_i    <= res_queue.pop_front();
        vec_result_data_i  <= $urandom;
        res_wait           <= $urandom_range(4);
      end else begin
        vec_result_valid_i <= 1'b0;
        if (res_wait != 0) res_wait <= res_wait - 1;
      end
    end
  end

  // Result side monitor
  always @(negedge clk_i) begin
    res_taken = vec_result_valid_i && vec_result_ready_o;
    if (vec_result_valid_i && vec_result_id_i[5]) begin
      require(vec_result_ready_o, "FPR result was not taken in its first cycle");
      shadow[vec_result_id_i[4:0]] = vec_result_data_i;
      pending[vec_result_id_i[4:0]] = 1'b0;
    end else if (vec_result_valid_i) begin
      compare("core_result_valid_o", 32'(1'b1), 32'(core_result_valid_o));
      compare("core_result_id_o", 32'(vec_result_id_i), 32'(core_result_id_o));
      compare("core_result_data_o", vec_result_data_i, core_result_data_o);
      compare("vec_result_ready_o", 32'(core_result_ready_i), 32'(vec_result_ready_o));
    end else if (core_result_valid_o && !reset_i) begin
      if (move_q.size() == 0) begin
        require(1'b0, "core result shown with no move outstanding");
      end else begin
        compare("move id", 32'(move_q[0][37:32]), 32'(core_result_id_o));
        compare("move data", move_q[0][31:0], core_result_data_o);
        if (core_result_ready_i) begin
          void'(move_q.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////
  // Request generation and issue
  ////////////////////////////////////////

  // use_f bits are fd, fs3, fs2, fs1
  task automatic random_instr(input int kind, output fpu_seq_pkg::instr_t instr,
                              output bit [3:0] use_f);
    logic [4:0] arith [5] = '{fpu_seq_pkg::f5_add, fpu_seq_pkg::f5_sub, fpu_seq_pkg::f5_mul,
                              fpu_seq_pkg::f5_sgnj, fpu_seq_pkg::f5_minmax};
    logic [6:0] fused [4] = '{fpu_seq_pkg::opcode_fmadd, fpu_seq_pkg::opcode_fmsub,
                              fpu_seq_pkg::opcode_fnmsub, fpu_seq_pkg::opcode_fnmadd};
    instr = $urandom;
    // Few registers so that hazards come up often
    instr[11:7]  = 5'($urandom_range(15));
    instr[19:15] = 5'($urandom_range(15));
    instr[24:20] = 5'($urandom_range(15));
    instr[26:25] = fpu_seq_pkg::fmt_single;
    instr[6:0]   = fpu_seq_pkg::opcode_op_fp;
    case (kind)
      0: begin
        instr[31:27] = arith[$urandom_range(4)];
        use_f        = 4'b1011;
      end
      1: begin
        instr[31:27] = fpu_seq_pkg::f5_cmp;
        use_f        = 4'b0011;
      end
      2: begin
        instr[31:27] = fpu_seq_pkg::f5_cvt_w_s;
        use_f        = 4'b0001;
      end
      3: begin
        instr[31:27] = fpu_seq_pkg::f5_cvt_s_w;
        use_f        = 4'b1000;
      end
      4: begin
        instr[6:0]   = fused[$urandom_range(3)];
        instr[31:27] = 5'($urandom_range(15));
        use_f        = 4'b1111;
      end
      5: begin
        instr[6:0]   = fpu_seq_pkg::opcode_op_v;
        instr[14:12] = fpu_seq_pkg::funct3_opfvf;
        use_f        = 4'b0001;
      end
      6: begin
        instr[6:0] = 7'b0110011;
        use_f      = 4'b0000;
      end
      7: begin
        instr[31:27] = $urandom_range(1) ? fpu_seq_pkg::f5_div : fpu_seq_pkg::f5_sqrt;
        use_f        = 4'b0000;
      end
      8: begin
        instr[31:27] = fpu_seq_pkg::f5_mv_x_w;
        instr[14:12] = 3'b000;
        use_f        = 4'b0001;
      end
      default: begin
        instr[31:27] = fpu_seq_pkg::f5_mv_w_x;
        use_f        = 4'b1000;
      end
    endcase
  endtask

  function automatic bit touches_pending(input fpu_seq_pkg::instr_t instr, input bit [3:0] use_f);
    return (use_f[0] && pending[instr[19:15]]) || (use_f[1] && pending[instr[24:20]]) ||
           (use_f[2] && pending[instr[31:27]]) || (use_f[3] && pending[instr[11:7]]);
  endfunction

  task automatic issue(input fpu_seq_pkg::instr_t instr, input fpu_seq_pkg::fp_data_t rs1,
                       input bit [3:0] use_f, input int kind);
    fpu_seq_pkg::x_id_t    id;
    fpu_seq_pkg::x_id_t    exp_id;
    fpu_seq_pkg::fp_data_t rs2;
    fpu_seq_pkg::fp_data_t rs3;
    bit                    is_local;
    bit                    done;
    id       = {1'b0, 5'($urandom_range(31))};
    rs2      = $urandom;
    rs3      = $urandom;
    is_local = kind >= 7;
    exp_id   = use_f[3] ? {1'b1, instr[11:7]} : id;
    done     = 1'b0;
    @(posedge clk_i);
    core_issue_instr_i <= instr;
    core_issue_rs1_i   <= rs1;
    core_issue_rs2_i   <= rs2;
    core_issue_rs3_i   <= rs3;
    core_issue_id_i    <= id;
    core_issue_valid_i <= 1'b1;
    while (!done) begin
      @(negedge clk_i);
      if (vec_issue_valid_o || core_issue_ready_o)
        require(!touches_pending(instr, use_f), "request went out while a register was pending");
      if (core_issue_ready_o && !is_local)
        require(vec_issue_valid_o && vec_issue_ready_i,
                "request accepted without a vector-unit handshake");
      if (vec_issue_valid_o && vec_issue_ready_i)
        require(core_issue_ready_o, "vector unit took a request the core did not hand over");
      if (vec_issue_valid_o) begin
        require(!is_local, "local request reached the vector unit");
        compare("vec_issue_instr_o", instr, vec_issue_instr_o);
        compare("vec_issue_rs1_o", use_f[0] ? shadow[instr[19:15]] : rs1, vec_issue_rs1_o);
        compare("vec_issue_rs2_o", use_f[1] ? shadow[instr[24:20]] : rs2, vec_issue_rs2_o);
        compare("vec_issue_rs3_o", use_f[2] ? shadow[instr[31:27]] : rs3, vec_issue_rs3_o);
        compare("vec_issue_id_o", 32'(exp_id), 32'(vec_issue_id_o));
      end
      if (core_issue_ready_o) begin
        done = 1'b1;
        if (is_local) begin
          compare("core_resp_accept_o", 32'(kind == 8), 32'(core_resp_accept_o));
          compare("core_resp_writeback_o", 32'(kind == 8), 32'(core_resp_writeback_o));
          compare("core_resp_exc_o", 32'(kind == 7), 32'(core_resp_exc_o));
        end else begin
          compare("core_resp_accept_o", 32'(vec_resp_accept_i), 32'(core_resp_accept_o));
          compare("core_resp_writeback_o", 32'(vec_resp_writeback_i),
                  32'(core_resp_writeback_o));
          compare("core_resp_exc_o", 32'(vec_resp_exc_i), 32'(core_resp_exc_o));
          res_queue.push_back(exp_id);
          if (use_f[3]) pending[instr[11:7]] = 1'b1;
        end
        if (kind == 9) shadow[instr[11:7]] = rs1;
        if (kind == 8) begin
          move_q.push_back({id, shadow[instr[19:15]]});
        end
      end
    end
  endtask

  // Idle the issue port and wait for every result to retire
  task automatic drain;
    @(posedge clk_i);
    core_issue_valid_i <= 1'b0;
    while (res_queue.size() != 0 || vec_result_valid_i || move_q.size() != 0 || pending != 0)
      @(negedge clk_i);
  endtask

  task automatic read_all;
    fpu_seq_pkg::instr_t instr;
    bit [3:0]            use_f;
    for (int r = 0; r < 32; r++) begin
      random_instr(8, instr, use_f);
      instr[19:15] = 5'(r);
      issue(instr, $urandom, use_f, 8);
    end
  endtask

  task automatic run_random(input int count, input bit move_heavy);
    fpu_seq_pkg::instr_t instr;
    bit [3:0]            use_f;
    int                  kind;
    for (int i = 0; i < count; i++) begin
      kind = (move_heavy && $urandom_range(1) == 1) ? 8 : int'($urandom_range(9));
      random_instr(kind, instr, use_f);
      issue(instr, $urandom, use_f, kind);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test;
    $display("test %-20s %0d checks, %0d errors", cur_test, checks - test_checks,
             errors - test_errors);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    fpu_seq_pkg::instr_t instr;
    bit [3:0]            use_f;
    void'($urandom(32'hbb02_3bae));
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    begin_test("reg_load_readback");
    for (int r = 0; r < 32; r++) begin
      random_instr(9, instr, use_f);
      instr[11:7] = 5'(r);
      issue(instr, $urandom, use_f, 9);
    end
    read_all();
    drain();
    end_test();

    begin_test("random_mix");
    run_random(n_mix, 1'b0);
    drain();
    end_test();

    // Reads back what the vector results wrote
    begin_test("writeback_readback");
    read_all();
    drain();
    end_test();

    begin_test("back_pressure");
    ready_rate = 25;
    run_random(n_bp, 1'b1);
    drain();
    end_test();

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: hw/fpu_sequencer.sv
////////////////////////////////////////
// FP sequencer top
// Sits between the core coprocessor port
// and the vector unit
////////////////////////////////////////

`timescale 1ns/1ns

module fpu_sequencer #(
  parameter bit fdiv_sqrt_en = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Core issue
  input  fpu_seq_pkg::instr_t   core_issue_instr_i,
  input  fpu_seq_pkg::fp_data_t core_issue_rs1_i,
  input  fpu_seq_pkg::fp_data_t core_issue_rs2_i,
  input  fpu_seq_pkg::fp_data_t core_issue_rs3_i,
  input  fpu_seq_pkg::x_id_t    core_issue_id_i,
  input  logic                  core_issue_valid_i,
  output logic                  core_issue_ready_o,
  output logic                  core_resp_accept_o,
  output logic                  core_resp_writeback_o,
  output logic                  core_resp_exc_o,
  // Core result
  output fpu_seq_pkg::x_id_t    core_result_id_o,
  output fpu_seq_pkg::fp_data_t core_result_data_o,
  output logic                  core_result_valid_o,
  input  logic                  core_result_ready_i,
  // Vector issue
  output fpu_seq_pkg::instr_t   vec_issue_instr_o,
  output fpu_seq_pkg::fp_data_t vec_issue_rs1_o,
  output fpu_seq_pkg::fp_data_t vec_issue_rs2_o,
  output fpu_seq_pkg::fp_data_t vec_issue_rs3_o,
  output fpu_seq_pkg::x_id_t    vec_issue_id_o,
  output logic                  vec_issue_valid_o,
  input  logic                  vec_issue_ready_i,
  input  logic                  vec_resp_accept_i,
  input  logic                  vec_resp_writeback_i,
  input  logic                  vec_resp_exc_i,
  // Vector result
  input  fpu_seq_pkg::x_id_t    vec_result_id_i,
  input  fpu_seq_pkg::fp_data_t vec_result_data_i,
  input  logic                  vec_result_valid_i,
  output logic                  vec_result_ready_o
);

  fpu_seq_pkg::fp_reg_addr_t fd, fs1, fs2, fs3;
  logic use_fs1, use_fs2, use_fs3, use_fd, use_rd, is_move, illegal;
  logic hazard, move_full, sb_set, move_push, mv_w_x, clr;
  fpu_seq_pkg::fp_reg_addr_t clr_addr, waddr0, waddr1;
  fpu_seq_pkg::fp_data_t rdata1, rdata2, rdata3, wdata0, wdata1;
  logic we0, we1;

  fp_instr_decoder #(
    .fdiv_sqrt_en(fdiv_sqrt_en)
  ) u_decoder (
    .instr_i  (core_issue_instr_i),
    .valid_i  (core_issue_valid_i),
    .fd_o     (fd),
    .fs1_o    (fs1),
    .fs2_o    (fs2),
    .fs3_o    (fs3),
    .use_fs1_o(use_fs1),
    .use_fs2_o(use_fs2),
    .use_fs3_o(use_fs3),
    .use_fd_o (use_fd),
    .use_rd_o (use_rd),
    .is_move_o(is_move),
    .illegal_o(illegal)
  );

  fp_scoreboard u_scoreboard (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .fs1_i     (fs1),
    .fs2_i     (fs2),
    .fs3_i     (fs3),
    .fd_i      (fd),
    .use_fs1_i (use_fs1),
    .use_fs2_i (use_fs2),
    .use_fs3_i (use_fs3),
    .use_fd_i  (use_fd),
    .set_i     (sb_set),
    .clr_i     (clr),
    .clr_addr_i(clr_addr),
    .hazard_o  (hazard)
  );

  fp_regfile u_regfile (
    .clk_i   (clk_i),
    .raddr1_i(fs1),
    .raddr2_i(fs2),
    .raddr3_i(fs3),
    .waddr0_i(waddr0),
    .waddr1_i(waddr1),
    .wdata0_i(wdata0),
    .wdata1_i(wdata1),
    .we0_i   (we0),
    .we1_i   (we1),
    .rdata1_o(rdata1),
    .rdata2_o(rdata2),
    .rdata3_o(rdata3)
  );

  fp_dispatcher u_dispatcher (
    .core_issue_instr_i   (core_issue_instr_i),
    .core_issue_rs1_i     (core_issue_rs1_i),
    .core_issue_rs2_i     (core_issue_rs2_i),
    .core_issue_rs3_i     (core_issue_rs3_i),
    .core_issue_id_i      (core_issue_id_i),
    .core_issue_valid_i   (core_issue_valid_i),
    .vec_issue_ready_i    (vec_issue_ready_i),
    .vec_resp_accept_i    (vec_resp_accept_i),
    .vec_resp_writeback_i (vec_resp_writeback_i),
    .vec_resp_exc_i       (vec_resp_exc_i),
    .fd_i                 (fd),
    .use_fs1_i            (use_fs1),
    .use_fs2_i            (use_fs2),
    .use_fs3_i            (use_fs3),
    .use_fd_i             (use_fd),
    .use_rd_i             (use_rd),
    .is_move_i            (is_move),
    .illegal_i            (illegal),
    .rdata1_i             (rdata1),
    .rdata2_i             (rdata2),
    .rdata3_i             (rdata3),
    .hazard_i             (hazard),
    .move_full_i          (move_full),
    .vec_issue_instr_o    (vec_issue_instr_o),
    .vec_issue_rs1_o      (vec_issue_rs1_o),
    .vec_issue_rs2_o      (vec_issue_rs2_o),
    .vec_issue_rs3_o      (vec_issue_rs3_o),
    .vec_issue_id_o       (vec_issue_id_o),
    .vec_issue_valid_o    (vec_issue_valid_o),
    .core_issue_ready_o   (core_issue_ready_o),
    .core_resp_accept_o   (core_resp_accept_o),
    .core_resp_writeback_o(core_resp_writeback_o),
    .core_resp_exc_o      (core_resp_exc_o),
    .sb_set_o             (sb_set),
    .move_push_o          (move_push),
    .mv_w_x_o             (mv_w_x)
  );

  // FPR to GPR moves carry fs1 data, GPR to FPR moves carry rs1
  fp_retire_unit u_retire (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .move_push_i        (move_push),
    .move_id_i          (core_issue_id_i),
    .move_data_i        (rdata1),
    .mv_w_x_i           (mv_w_x),
    .mv_addr_i          (fd),
    .mv_data_i          (core_issue_rs1_i),
    .vec_result_id_i    (vec_result_id_i),
    .vec_result_data_i  (vec_result_data_i),
    .vec_result_valid_i (vec_result_valid_i),
    .core_result_ready_i(core_result_ready_i),
    .move_full_o        (move_full),
    .vec_result_ready_o (vec_result_ready_o),
    .core_result_id_o   (core_result_id_o),
    .core_result_data_o (core_result_data_o),
    .core_result_valid_o(core_result_valid_o),
    .we0_o              (we0),
    .waddr0_o           (waddr0),
    .wdata0_o           (wdata0),
    .we1_o              (we1),
    .waddr1_o           (waddr1),
    .wdata1_o           (wdata1),
    .clr_o              (clr),
    .clr_addr_o         (clr_addr)
  );

endmodule

// File: hw/fp_retire_unit.sv
////////////////////////////////////////
// FP retire unit
// Holds move results and steers vector
// results to the core or the FPR
////////////////////////////////////////

`timescale 1ns/1ns

module fp_retire_unit (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      move_push_i,
  input  fpu_seq_pkg::x_id_t        move_id_i,
  input  fpu_seq_pkg::fp_data_t     move_data_i,
  input  logic                      mv_w_x_i,
  input  fpu_seq_pkg::fp_reg_addr_t mv_addr_i,
  input  fpu_seq_pkg::fp_data_t     mv_data_i,
  input  fpu_seq_pkg::x_id_t        vec_result_id_i,
  input  fpu_seq_pkg::fp_data_t     vec_result_data_i,
  input  logic                      vec_result_valid_i,
  input  logic                      core_result_ready_i,
  output logic                      move_full_o,
  output logic                      vec_result_ready_o,
  output fpu_seq_pkg::x_id_t        core_result_id_o,
  output fpu_seq_pkg::fp_data_t     core_result_data_o,
  output logic                      core_result_valid_o,
  output logic                      we0_o,
  output fpu_seq_pkg::fp_reg_addr_t waddr0_o,
  output fpu_seq_pkg::fp_data_t     wdata0_o,
  output logic                      we1_o,
  output fpu_seq_pkg::fp_reg_addr_t waddr1_o,
  output fpu_seq_pkg::fp_data_t     wdata1_o,
  output logic                      clr_o,
  output fpu_seq_pkg::fp_reg_addr_t clr_addr_o
);

  logic                  mv_valid_q;
  fpu_seq_pkg::x_id_t    mv_id_q;
  fpu_seq_pkg::fp_data_t mv_data_q;
  logic                  mv_pop;

  ////////////////////////////////////////
  // Move result register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mv_valid_q <= 1'b0;
    end else if (move_push_i) begin
      mv_valid_q <= 1'b1;
    end else if (mv_pop) begin
      mv_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (move_push_i) begin
      mv_id_q   <= move_id_i;
      mv_data_q <= move_data_i;
    end
  end

  // Room for a new entry when empty or draining this cycle
  assign move_full_o = mv_valid_q && !mv_pop;

  ////////////////////////////////////////
  // Result arbitration
  ////////////////////////////////////////

  always_comb begin
    core_result_id_o    = mv_id_q;
    core_result_data_o  = mv_data_q;
    core_result_valid_o = 1'b0;
    vec_result_ready_o  = 1'b0;
    mv_pop              = 1'b0;
    we0_o               = 1'b0;
    clr_o               = 1'b0;

    if (vec_result_valid_i && !vec_result_id_i[5]) begin
      // Integer result goes straight to the core
      core_result_id_o    = vec_result_id_i;
      core_result_data_o  = vec_result_data_i;
      core_result_valid_o = 1'b1;
      vec_result_ready_o  = core_result_ready_i;
    end else if (vec_result_valid_i) begin
      vec_result_ready_o = 1'b1;
      we0_o              = 1'b1;
      clr_o              = 1'b1;
    end else if (mv_valid_q) begin
      core_result_valid_o = 1'b1;
      mv_pop              = core_result_ready_i;
    end
  end

  assign waddr0_o   = vec_result_id_i[4:0];
  assign wdata0_o   = vec_result_data_i;
  assign clr_addr_o = vec_result_id_i[4:0];

  // GPR to FPR moves own write port 1
  assign we1_o    = mv_w_x_i;
  assign waddr1_o = mv_addr_i;
  assign wdata1_o = mv_data_i;

endmodule

// File: hw/fp_dispatcher.sv
////////////////////////////////////////
// FP dispatcher
// Stalls, swaps in FP operands and sends
// the request local or to the vector unit
////////////////////////////////////////

`timescale 1ns/1ns

module fp_dispatcher (
  input  fpu_seq_pkg::instr_t       core_issue_instr_i,
  input  fpu_seq_pkg::fp_data_t     core_issue_rs1_i,
  input  fpu_seq_pkg::fp_data_t     core_issue_rs2_i,
  input  fpu_seq_pkg::fp_data_t     core_issue_rs3_i,
  input  fpu_seq_pkg::x_id_t        core_issue_id_i,
  input  logic                      core_issue_valid_i,
  input  logic                      vec_issue_ready_i,
  input  logic                      vec_resp_accept_i,
  input  logic                      vec_resp_writeback_i,
  input  logic                      vec_resp_exc_i,
  input  fpu_seq_pkg::fp_reg_addr_t fd_i,
  input  logic                      use_fs1_i,
  input  logic                      use_fs2_i,
  input  logic                      use_fs3_i,
  input  logic                      use_fd_i,
  input  logic                      use_rd_i,
  input  logic                      is_move_i,
  input  logic                      illegal_i,
  input  fpu_seq_pkg::fp_data_t     rdata1_i,
  input  fpu_seq_pkg::fp_data_t     rdata2_i,
  input  fpu_seq_pkg::fp_data_t     rdata3_i,
  input  logic                      hazard_i,
  input  logic                      move_full_i,
  output fpu_seq_pkg::instr_t       vec_issue_instr_o,
  output fpu_seq_pkg::fp_data_t     vec_issue_rs1_o,
  output fpu_seq_pkg::fp_data_t     vec_issue_rs2_o,
  output fpu_seq_pkg::fp_data_t     vec_issue_rs3_o,
  output fpu_seq_pkg::x_id_t        vec_issue_id_o,
  output logic                      vec_issue_valid_o,
  output logic                      core_issue_ready_o,
  output logic                      core_resp_accept_o,
  output logic                      core_resp_writeback_o,
  output logic                      core_resp_exc_o,
  output logic                      sb_set_o,
  output logic                      move_push_o,
  output logic                      mv_w_x_o
);

  logic is_local;
  logic stall;
  logic accept;

  assign is_local = is_move_i || illegal_i;
  // A move to the GPR needs room in the move register
  assign stall    = hazard_i || (is_move_i && use_rd_i && move_full_i);

  assign vec_issue_valid_o  = core_issue_valid_i && !stall && !is_local;
  assign core_issue_ready_o = !stall && (is_local || vec_issue_ready_i);
  assign accept             = core_issue_valid_i && core_issue_ready_o;

  ////////////////////////////////////////
  // Operand substitution
  ////////////////////////////////////////

  assign vec_issue_instr_o = core_issue_instr_i;
  assign vec_issue_rs1_o   = use_fs1_i ? rdata1_i : core_issue_rs1_i;
  assign vec_issue_rs2_o   = use_fs2_i ? rdata2_i : core_issue_rs2_i;
  assign vec_issue_rs3_o   = use_fs3_i ? rdata3_i : core_issue_rs3_i;
  assign vec_issue_id_o    = use_fd_i ? {1'b1, fd_i} : {1'b0, core_issue_id_i[4:0]};

  // Local requests answer for themselves
  assign core_resp_accept_o    = is_local ? use_rd_i  : vec_resp_accept_i;
  assign core_resp_writeback_o = is_local ? use_rd_i  : vec_resp_writeback_i;
  assign core_resp_exc_o       = is_local ? illegal_i : vec_resp_exc_i;

  assign sb_set_o    = accept && use_fd_i && !is_move_i;
  assign move_push_o = accept && is_move_i && use_rd_i;
  assign mv_w_x_o    = accept && is_move_i && use_fd_i;

endmodule

// File: hw/fp_instr_decoder.sv
////////////////////////////////////////
// FP instruction decoder
// Finds which FP registers a request
// reads and writes, and spots moves
////////////////////////////////////////

`timescale 1ns/1ns

module fp_instr_decoder #(
  parameter bit fdiv_sqrt_en = 1'b1
) (
  input  fpu_seq_pkg::instr_t       instr_i,
  input  logic                      valid_i,
  output fpu_seq_pkg::fp_reg_addr_t fd_o,
  output fpu_seq_pkg::fp_reg_addr_t fs1_o,
  output fpu_seq_pkg::fp_reg_addr_t fs2_o,
  output fpu_seq_pkg::fp_reg_addr_t fs3_o,
  output logic                      use_fs1_o,
  output logic                      use_fs2_o,
  output logic                      use_fs3_o,
  output logic                      use_fd_o,
  output logic                      use_rd_o,
  output logic                      is_move_o,
  output logic                      illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [1:0] fmt;
  logic [4:0] funct5;
  logic       is_fused;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign fmt    = instr_i[26:25];
  assign funct5 = instr_i[31:27];

  assign fd_o  = instr_i[fpu_seq_pkg::fd_lsb  +: $bits(fpu_seq_pkg::fp_reg_addr_t)];
  assign fs1_o = instr_i[fpu_seq_pkg::fs1_lsb +: $bits(fpu_seq_pkg::fp_reg_addr_t)];
  assign fs2_o = instr_i[fpu_seq_pkg::fs2_lsb +: $bits(fpu_seq_pkg::fp_reg_addr_t)];
  assign fs3_o = instr_i[fpu_seq_pkg::fs3_lsb +: $bits(fpu_seq_pkg::fp_reg_addr_t)];

  assign is_fused = opcode inside {fpu_seq_pkg::opcode_fmadd, fpu_seq_pkg::opcode_fmsub,
                                   fpu_seq_pkg::opcode_fnmsub, fpu_seq_pkg::opcode_fnmadd};

  always_comb begin
    use_fs1_o = 1'b0;
    use_fs2_o = 1'b0;
    use_fs3_o = 1'b0;
    use_fd_o  = 1'b0;
    use_rd_o  = 1'b0;
    is_move_o = 1'b0;
    illegal_o = 1'b0;

    if (valid_i && is_fused && fmt == fpu_seq_pkg::fmt_single) begin
      use_fs1_o = 1'b1;
      use_fs2_o = 1'b1;
      use_fs3_o = 1'b1;
      use_fd_o  = 1'b1;
    end else if (valid_i && opcode == fpu_seq_pkg::opcode_op_fp &&
                 fmt == fpu_seq_pkg::fmt_single) begin
      unique case (funct5)
        fpu_seq_pkg::f5_add, fpu_seq_pkg::f5_sub, fpu_seq_pkg::f5_mul,
        fpu_seq_pkg::f5_sgnj, fpu_seq_pkg::f5_minmax: begin
          use_fs1_o = 1'b1;
          use_fs2_o = 1'b1;
          use_fd_o  = 1'b1;
        end
        fpu_seq_pkg::f5_div, fpu_seq_pkg::f5_sqrt: begin
          // Trapped here when the divider is not built
          illegal_o = !fdiv_sqrt_en;
          use_fs1_o = fdiv_sqrt_en;
          use_fs2_o = fdiv_sqrt_en && funct5 == fpu_seq_pkg::f5_div;
          use_fd_o  = fdiv_sqrt_en;
        end
        fpu_seq_pkg::f5_cmp: begin
          use_fs1_o = 1'b1;
          use_fs2_o = 1'b1;
        end
        fpu_seq_pkg::f5_cvt_w_s: use_fs1_o = 1'b1;
        fpu_seq_pkg::f5_cvt_s_w: use_fd_o = 1'b1;
        fpu_seq_pkg::f5_mv_x_w: begin
          // fclass stays in the vector unit
          use_fs1_o = 1'b1;
          use_rd_o  = funct3 != 3'b001;
          is_move_o = funct3 != 3'b001;
        end
        fpu_seq_pkg::f5_mv_w_x: begin
          use_fd_o  = 1'b1;
          is_move_o = 1'b1;
        end
        default: ;
      endcase
    end else if (valid_i && opcode == fpu_seq_pkg::opcode_op_v &&
                 funct3 == fpu_seq_pkg::funct3_opfvf) begin
      // Scalar operand of a .vf instruction
      use_fs1_o = 1'b1;
    end
  end

endmodule

// File: hw/fp_scoreboard.sv
////////////////////////////////////////
// FP scoreboard
// One pending bit per register, checked
// against the operands of the request
////////////////////////////////////////

`timescale 1ns/1ns

module fp_scoreboard (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  fpu_seq_pkg::fp_reg_addr_t fs1_i,
  input  fpu_seq_pkg::fp_reg_addr_t fs2_i,
  input  fpu_seq_pkg::fp_reg_addr_t fs3_i,
  input  fpu_seq_pkg::fp_reg_addr_t fd_i,
  input  logic                      use_fs1_i,
  input  logic                      use_fs2_i,
  input  logic                      use_fs3_i,
  input  logic                      use_fd_i,
  input  logic                      set_i,
  input  logic                      clr_i,
  input  fpu_seq_pkg::fp_reg_addr_t clr_addr_i,
  output logic                      hazard_o
);

  logic [fpu_seq_pkg::nr_fp_regs-1:0] pending_q;
  logic [fpu_seq_pkg::nr_fp_regs-1:0] pending_d;

  // Set after clear, so a new writer keeps the bit
  always_comb begin
    pending_d = pending_q;
    if (clr_i) pending_d[clr_addr_i] = 1'b0;
    if (set_i) pending_d[fd_i] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  // WAW on fd counts as well
  assign hazard_o = (use_fs1_i && pending_q[fs1_i]) ||
                    (use_fs2_i && pending_q[fs2_i]) ||
                    (use_fs3_i && pending_q[fs3_i]) ||
                    (use_fd_i  && pending_q[fd_i]);

endmodule

// File: hw/fp_regfile.sv
////////////////////////////////////////
// FP register file
// Three combinational reads, two writes
////////////////////////////////////////

`timescale 1ns/1ns

module fp_regfile (
  input  logic                      clk_i,
  input  fpu_seq_pkg::fp_reg_addr_t raddr1_i,
  input  fpu_seq_pkg::fp_reg_addr_t raddr2_i,
  input  fpu_seq_pkg::fp_reg_addr_t raddr3_i,
  input  fpu_seq_pkg::fp_reg_addr_t waddr0_i,
  input  fpu_seq_pkg::fp_reg_addr_t waddr1_i,
  input  fpu_seq_pkg::fp_data_t     wdata0_i,
  input  fpu_seq_pkg::fp_data_t     wdata1_i,
  input  logic                      we0_i,
  input  logic                      we1_i,
  output fpu_seq_pkg::fp_data_t     rdata1_o,
  output fpu_seq_pkg::fp_data_t     rdata2_o,
  output fpu_seq_pkg::fp_data_t     rdata3_o
);

  fpu_seq_pkg::fp_data_t mem [fpu_seq_pkg::nr_fp_regs];

  // Port 1 comes last so it wins on an address clash
  always_ff @(posedge clk_i) begin
    if (we0_i) mem[waddr0_i] <= wdata0_i;
    if (we1_i) mem[waddr1_i] <= wdata1_i;
  end

  assign rdata1_o = mem[raddr1_i];
  assign rdata2_o = mem[raddr2_i];
  assign rdata3_o = mem[raddr3_i];

endmodule

// File: hw/fpu_seq_pkg.sv
////////////////////////////////////////
// FP sequencer package
// Widths, register count and the
// instruction encodings the decoder needs
////////////////////////////////////////

package fpu_seq_pkg;

  parameter int unsigned flen       = 32;
  parameter int unsigned nr_fp_regs = 32;

  typedef logic [flen-1:0]               fp_data_t;
  typedef logic [$clog2(nr_fp_regs)-1:0] fp_reg_addr_t;
  typedef logic [31:0]                   instr_t;
  // Bit 5 set means bits 4:0 name an FP destination
  typedef logic [5:0]                    x_id_t;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////

  parameter logic [6:0] opcode_op_fp  = 7'b1010011;
  parameter logic [6:0] opcode_fmadd  = 7'b1000011;
  parameter logic [6:0] opcode_fmsub  = 7'b1000111;
  parameter logic [6:0] opcode_fnmsub = 7'b1001011;
  parameter logic [6:0] opcode_fnmadd = 7'b1001111;
  parameter logic [6:0] opcode_op_v   = 7'b1010111;

  parameter logic [2:0] funct3_opfvf = 3'b101;
  parameter logic [1:0] fmt_single   = 2'b00;

  // funct5 values of OP-FP
  parameter logic [4:0] f5_add     = 5'b00000;
  parameter logic [4:0] f5_sub     = 5'b00001;
  parameter logic [4:0] f5_mul     = 5'b00010;
  parameter logic [4:0] f5_div     = 5'b00011;
  parameter logic [4:0] f5_sqrt    = 5'b01011;
  parameter logic [4:0] f5_sgnj    = 5'b00100;
  parameter logic [4:0] f5_minmax  = 5'b00101;
  parameter logic [4:0] f5_cmp     = 5'b10100;
  parameter logic [4:0] f5_cvt_w_s = 5'b11000;
  parameter logic [4:0] f5_cvt_s_w = 5'b11010;
  // Shared with fclass, told apart by funct3
  parameter logic [4:0] f5_mv_x_w  = 5'b11100;
  parameter logic [4:0] f5_mv_w_x  = 5'b11110;

  // Register field positions
  parameter int unsigned fd_lsb  = 7;
  parameter int unsigned fs1_lsb = 15;
  parameter int unsigned fs2_lsb = 20;
  parameter int unsigned fs3_lsb = 27;

endpackage
